// File: common/mic_macros.svh
`ifndef MIC_MACROS_SVH
`define MIC_MACROS_SVH

// ====================
// audio word format
// ====================
`define SAMPLE_BITS 16          // pcm bits per channel

// ====================
// binomial low-pass taps
// ====================
// c0 weights the newest sample
`define FIR_C0 1
`define FIR_C1 3
`define FIR_C2 3
`define FIR_C3 1
`define FIR_SHIFT 3             // taps sum to 8

// ====================
// front end
// ====================
`define SYNC_STAGES 2           // flops per async input
`define SRC_CODEC 0             // select value for adcdat

`endif

// File: common/mic_pkg.sv
`default_nettype none

`include "mic_macros.svh"

package mic_pkg;

        // one channel of audio
        typedef logic signed [`SAMPLE_BITS-1:0] pcm_sample_t;

        // weighted tap sum, 3 guard bits since weights add up to 8
        typedef logic signed [`SAMPLE_BITS+`FIR_SHIFT-1:0] fir_acc_t;

        // stereo word, left in upper half
        typedef logic [2*`SAMPLE_BITS-1:0] frame_t;

        // serial source number
        typedef logic [2:0] src_sel_t;  // 0 codec, 1..4 mics, rest codec

        // stream controller states
        typedef enum logic [2:0] {
                IDLE,                   // wait for captured frame
                LOAD,                   // ack capture, strobe filters
                FILTER,                 // fir result settles
                HANDOFF,                // stream word out, wait playback
                RELEASE                 // wait for play_ack to drop
        } ctrl_state_t;

endpackage

`default_nettype wire

// File: i2s/i2s_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "mic_macros.svh"

module i2s_capture
        import mic_pkg::*;
(
        input  logic     clk,
        input  logic     rst_n,
        input  logic     bclk,
        input  logic     lrclk,         // low left, high right
        input  logic     adcdat,
        input  logic     din1,
        input  logic     din2,
        input  logic     din3,
        input  logic     din4,
        input  src_sel_t src_sel,
        input  logic     cap_ack,
        output logic     cap_req,
        output frame_t   cap_frame,
        output logic     bclk_fall,     // strobes for playback
        output logic     lrclk_fall
);

        logic [`SYNC_STAGES-1:0] bclk_sync;
        logic [`SYNC_STAGES-1:0] lrclk_sync;
        logic [`SYNC_STAGES-1:0] data_sync;
        logic bclk_d;
        logic lrclk_d;
        logic line;
        logic bclk_rise;
        logic lrclk_rise;
        logic frame_done;
        logic armed;                    // a full left half has been seen
        logic [$clog2(`SAMPLE_BITS+1)-1:0] bit_cnt;
        pcm_sample_t shift_reg;
        pcm_sample_t left_reg;

        // ====================
        // source select
        // ====================
        always_comb begin
                case (src_sel)
                src_sel_t'(`SRC_CODEC): line = adcdat;
                3'd1:    line = din1;
                3'd2:    line = din2;
                3'd3:    line = din3;
                3'd4:    line = din4;
                default: line = adcdat; // unused selects fall back to codec
                endcase
        end

        // data goes through the same depth as bclk so they stay aligned
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        bclk_sync  <= '0;
                        lrclk_sync <= '0;
                        data_sync  <= '0;
                        bclk_d     <= 1'b0;
                        lrclk_d    <= 1'b0;
                end else begin
                        bclk_sync  <= {bclk_sync[`SYNC_STAGES-2:0], bclk};
                        lrclk_sync <= {lrclk_sync[`SYNC_STAGES-2:0], lrclk};
                        data_sync  <= {data_sync[`SYNC_STAGES-2:0], line};
                        bclk_d     <= bclk_sync[`SYNC_STAGES-1];
                        lrclk_d    <= lrclk_sync[`SYNC_STAGES-1];
                end
        end

        assign bclk_rise  =  bclk_sync[`SYNC_STAGES-1] & ~bclk_d;
        assign bclk_fall  = ~bclk_sync[`SYNC_STAGES-1] &  bclk_d;
        assign lrclk_rise =  lrclk_sync[`SYNC_STAGES-1] & ~lrclk_d;
        assign lrclk_fall = ~lrclk_sync[`SYNC_STAGES-1] &  lrclk_d;

        // right half ends, frame dropped if the last one is still pending
        assign frame_done = lrclk_fall && armed && !cap_req && !cap_ack;

        // ====================
        // bit count and request
        // ====================
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        bit_cnt <= '0;
                        armed   <= 1'b0;
                        cap_req <= 1'b0;
                end else begin
                        if (lrclk_rise || lrclk_fall)
                                bit_cnt <= '0;          // msb comes next
                        else if (bclk_rise && bit_cnt < `SAMPLE_BITS)
                                bit_cnt <= bit_cnt + 1'b1;
                        if (lrclk_fall)
                                armed <= 1'b1;
                        if (frame_done)
                                cap_req <= 1'b1;
                        else if (cap_req && cap_ack)
                                cap_req <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (bclk_rise && !lrclk_rise && !lrclk_fall && bit_cnt < `SAMPLE_BITS)
                        shift_reg <= {shift_reg[`SAMPLE_BITS-2:0], data_sync[`SYNC_STAGES-1]};
                if (lrclk_rise)
                        left_reg <= shift_reg;
                if (frame_done)
                        cap_frame <= {left_reg, shift_reg};
        end

endmodule

`default_nettype wire

// File: i2s/i2s_playback.sv
`timescale 1ns/1ps
`default_nettype none

`include "mic_macros.svh"

module i2s_playback
        import mic_pkg::*;
(
        input  logic   clk,
        input  logic   rst_n,
        input  logic   play_req,
        input  frame_t play_frame,
        input  logic   bclk_fall,       // synced strobes from capture
        input  logic   lrclk_fall,
        output logic   play_ack,
        output logic   dacdat
);

        frame_t     hold_reg;
        frame_t     shifter;
        logic       hold_full;
        logic [6:0] slot_cnt;           // bclk falls since lrclk fall
        logic [6:0] slot_nxt;
        logic [6:0] half_len;           // measured from the previous frame
        logic       bit_slot;

        assign slot_nxt = slot_cnt + 7'd1;
        // one slot delay after each lrclk edge, then 16 bits
        assign bit_slot = (slot_nxt <= `SAMPLE_BITS) ||
                          (slot_nxt > half_len && slot_nxt <= half_len + `SAMPLE_BITS);

        // ====================
        // holding register
        // ====================
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        hold_reg  <= '0;
                        hold_full <= 1'b0;
                        play_ack  <= 1'b0;
                end else begin
                        if (lrclk_fall)
                                hold_full <= 1'b0;      // moved to shifter
                        if (play_req && !play_ack && !hold_full) begin
                                hold_reg  <= play_frame;
                                hold_full <= 1'b1;
                                play_ack  <= 1'b1;
                        end else if (play_ack && !play_req) begin
                                play_ack <= 1'b0;
                        end
                end
        end

        // ====================
        // serializer
        // ====================
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        shifter  <= '0;
                        slot_cnt <= '0;
                        half_len <= 7'(`SAMPLE_BITS);
                        dacdat   <= 1'b0;
                end else if (lrclk_fall) begin
                        shifter  <= hold_full ? hold_reg : '0;  // silence if empty
                        half_len <= slot_nxt >> 1;
                        slot_cnt <= '0;
                        // right lsb shares its slot with the word clock fall
                        dacdat   <= bit_slot ? shifter[2*`SAMPLE_BITS-1] : 1'b0;
                end else if (bclk_fall) begin
                        slot_cnt <= slot_nxt;
                        if (bit_slot) begin
                                dacdat  <= shifter[2*`SAMPLE_BITS-1];   // msb first
                                shifter <= shifter << 1;
                        end else begin
                                dacdat <= 1'b0;
                        end
                end
        end

endmodule

`default_nettype wire

// File: fir/fir_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "mic_macros.svh"

module fir_channel
        import mic_pkg::*;
(
        input  logic        clk,
        input  logic        rst_n,
        input  logic        load,       // new sample strobe
        input  pcm_sample_t sample_in,
        output pcm_sample_t sample_out
);

        // tap weights at accumulator width
        localparam fir_acc_t W0 = fir_acc_t'(`FIR_C0);
        localparam fir_acc_t W1 = fir_acc_t'(`FIR_C1);
        localparam fir_acc_t W2 = fir_acc_t'(`FIR_C2);
        localparam fir_acc_t W3 = fir_acc_t'(`FIR_C3);

        pcm_sample_t hist_1;            // previous sample
        pcm_sample_t hist_2;
        pcm_sample_t hist_3;            // oldest
        fir_acc_t    acc;

        // ====================
        // weighted sum
        // ====================
        // sign extended before weighting, full scale fits in 19 bits
        always_comb begin
                acc = W0 * fir_acc_t'(sample_in)
                    + W1 * fir_acc_t'(hist_1)
                    + W2 * fir_acc_t'(hist_2)
                    + W3 * fir_acc_t'(hist_3);
        end

        // history starts from silence
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        hist_1     <= '0;
                        hist_2     <= '0;
                        hist_3     <= '0;
                        sample_out <= '0;
                end else if (load) begin
                        hist_1     <= sample_in;
                        hist_2     <= hist_1;
                        hist_3     <= hist_2;
                        // arithmetic shift truncates toward minus infinity
                        sample_out <= pcm_sample_t'(acc >>> `FIR_SHIFT);
                end
        end

endmodule

`default_nettype wire

// File: src/stream_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mic_macros.svh"

module stream_ctrl
        import mic_pkg::*;
(
        input  logic        clk,
        input  logic        rst_n,
        input  logic        cap_req,        // frame ready from capture
        input  frame_t      cap_frame,
        input  logic        fir_en,         // 0 bypasses the filters
        input  pcm_sample_t fir_left_out,
        input  pcm_sample_t fir_right_out,
        input  logic        play_ack,
        output logic        cap_ack,
        output logic        fir_load,       // one cycle strobe
        output pcm_sample_t fir_left_in,
        output pcm_sample_t fir_right_in,
        output logic        play_req,
        output frame_t      play_frame,
        output frame_t      stream_data,
        output logic        stream_valid
);

        ctrl_state_t state;
        pcm_sample_t left_raw;
        pcm_sample_t right_raw;
        logic        accept;

        // new frame only once the previous ack has been withdrawn
        assign accept = (state == IDLE) && cap_req && !cap_ack;

        // ====================
        // sample copy
        // ====================
        always_ff @(posedge clk) begin
                if (accept) begin
                        left_raw  <= cap_frame[2*`SAMPLE_BITS-1:`SAMPLE_BITS];
                        right_raw <= cap_frame[`SAMPLE_BITS-1:0];
                end
        end

        assign fir_left_in  = left_raw;
        assign fir_right_in = right_raw;
        assign play_frame   = stream_data;  // stable for the whole play_req

        // ====================
        // sequencer
        // ====================
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state        <= IDLE;
                        cap_ack      <= 1'b0;
                        fir_load     <= 1'b0;
                        play_req     <= 1'b0;
                        stream_valid <= 1'b0;
                        stream_data  <= '0;
                end else begin
                        fir_load     <= 1'b0;
                        stream_valid <= 1'b0;
                        if (cap_ack && !cap_req)
                                cap_ack <= 1'b0;        // phase 4 of capture handshake
                        case (state)
                        IDLE: begin
                                if (accept) begin
                                        cap_ack  <= 1'b1;
                                        fir_load <= 1'b1;       // history moves on every frame
                                        state    <= LOAD;
                                end
                        end
                        LOAD: begin
                                if (fir_en) begin
                                        state <= FILTER;
                                end else begin
                                        stream_data  <= {left_raw, right_raw};
                                        stream_valid <= 1'b1;
                                        play_req     <= 1'b1;
                                        state        <= HANDOFF;
                                end
                        end
                        FILTER: begin           // fir outputs valid here
                                stream_data  <= {fir_left_out, fir_right_out};
                                stream_valid <= 1'b1;
                                play_req     <= 1'b1;
                                state        <= HANDOFF;
                        end
                        HANDOFF: begin          // stalls while playback is full
                                if (play_ack) begin
                                        play_req <= 1'b0;
                                        state    <= RELEASE;
                                end
                        end
                        RELEASE: begin
                                if (!play_ack)
                                        state <= IDLE;
                        end
                        default: state <= IDLE;
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: src/mic_array_top.sv
`timescale 1ns/1ps
`default_nettype none

module mic_array_top
        import mic_pkg::*;
(
        input  logic     clk,           // 50 MHz board clock
        input  logic     rst_n,
        input  logic     bclk,          // from codec, async to clk
        input  logic     lrclk,
        input  logic     adcdat,
        input  logic     din1,
        input  logic     din2,
        input  logic     din3,
        input  logic     din4,
        input  src_sel_t src_sel,
        input  logic     fir_en,
        output logic     dacdat,
        output logic     mic_bclk,
        output logic     mic_lrclk,
        output frame_t   stream_data,
        output logic     stream_valid
);

        logic        cap_req;
        logic        cap_ack;
        frame_t      cap_frame;
        logic        bclk_fall;
        logic        lrclk_fall;
        logic        fir_load;
        pcm_sample_t fir_left_in;
        pcm_sample_t fir_right_in;
        pcm_sample_t fir_left_out;
        pcm_sample_t fir_right_out;
        logic        play_req;
        logic        play_ack;
        frame_t      play_frame;

        // the mics run off the codec bit and word clocks
        assign mic_bclk  = bclk;
        assign mic_lrclk = lrclk;

        i2s_capture u_capture (
                .clk(clk), .rst_n(rst_n),
                .bclk(bclk), .lrclk(lrclk),
                .adcdat(adcdat), .din1(din1), .din2(din2), .din3(din3), .din4(din4),
                .src_sel(src_sel), .cap_ack(cap_ack),
                .cap_req(cap_req), .cap_frame(cap_frame),
                .bclk_fall(bclk_fall), .lrclk_fall(lrclk_fall)
        );

        stream_ctrl u_ctrl (
                .clk(clk), .rst_n(rst_n),
                .cap_req(cap_req), .cap_frame(cap_frame), .fir_en(fir_en),
                .fir_left_out(fir_left_out), .fir_right_out(fir_right_out),
                .play_ack(play_ack), .cap_ack(cap_ack), .fir_load(fir_load),
                .fir_left_in(fir_left_in), .fir_right_in(fir_right_in),
                .play_req(play_req), .play_frame(play_frame),
                .stream_data(stream_data), .stream_valid(stream_valid)
        );

        // one filter per channel, loaded together
        fir_channel fir_left (
                .clk(clk), .rst_n(rst_n), .load(fir_load),
                .sample_in(fir_left_in), .sample_out(fir_left_out)
        );

        fir_channel fir_right (
                .clk(clk), .rst_n(rst_n), .load(fir_load),
                .sample_in(fir_right_in), .sample_out(fir_right_out)
        );

        i2s_playback u_playback (
                .clk(clk), .rst_n(rst_n),
                .play_req(play_req), .play_frame(play_frame),
                .bclk_fall(bclk_fall), .lrclk_fall(lrclk_fall),
                .play_ack(play_ack), .dacdat(dacdat)
        );

endmodule

`default_nettype wire

// File: tb/mic_array_props.sv
`timescale 1ns/1ps
`default_nettype none

module mic_array_props (
        input logic clk,
        input logic rst_n,
        input logic cap_req,
        input logic cap_ack,
        input logic play_req,
        input logic play_ack,
        input logic stream_valid
);

        // ====================
        // capture handshake
        // ====================
        cap_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
                cap_req && !cap_ack |=> cap_req)
                else $error("cap_req dropped before cap_ack");

        cap_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
                cap_ack && cap_req |=> cap_ack)
                else $error("cap_ack dropped while cap_req high");

        // ====================
        // playback handshake
        // ====================
        play_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
                play_req && !play_ack |=> play_req)
                else $error("play_req dropped before play_ack");

        play_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
                play_ack && play_req |=> play_ack)
                else $error("play_ack dropped while play_req high");

        // one cycle strobe
        valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                stream_valid |=> !stream_valid)
                else $error("stream_valid longer than one cycle");

endmodule

bind stream_ctrl mic_array_props u_props (
        .clk(clk), .rst_n(rst_n),
        .cap_req(cap_req), .cap_ack(cap_ack),
        .play_req(play_req), .play_ack(play_ack),
        .stream_valid(stream_valid)
);

`default_nettype wire

// File: tb/tb_mic_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mic_macros.svh"

module tb_mic_array
        import mic_pkg::*;
;

        localparam integer CLK_NS   = 40;
        localparam integer FRAME_NS = 256 * CLK_NS;     // 32 bclk of 8 clk each
        localparam integer LIMIT_NS = 40 * FRAME_NS + 20 * CLK_NS;

        logic clk, rst_n, bclk, lrclk, adcdat, din1, din2, din3, din4, fir_en;
        src_sel_t src_sel;
        logic dacdat, mic_bclk, mic_lrclk, stream_valid;
        frame_t stream_data;

        integer seed = 32'h9ea9;
        integer errors = 0;
        integer checks = 0;
        integer cur_frame = -1;         // codec frame now on the wire
        logic codec_run = 1'b0;
        logic [2:0] bdiv = '0;
        event frame_start;

        logic [15:0] smp_l [0:4];       // per line, codec then mics
        logic [15:0] smp_r [0:4];
        frame_t dac_frames [0:63];      // words decoded from dacdat per frame
        frame_t got_q[$];
        logic en_q[$];
        frame_t exp_raw_q[$];
        frame_t exp_fir_q[$];
        frame_t play_q[$];              // model words, in stream order
        integer play_f_q[$];

        mic_array_top i_mic_array_top (.*);

        always #(CLK_NS/2) clk = ~clk;

        // bclk is clk/8, edges on clk falls
        always @(negedge clk) begin
                if (codec_run) begin
                        bdiv <= bdiv + 3'd1;
                        if (bdiv == 3'd3 || bdiv == 3'd7)
                                bclk <= ~bclk;
                end
        end

        // ====================
        // codec and mic model
        // ====================
        initial begin : codec_model
                integer s, i, sel_idx;
                integer x, h1, h2, h3, acc_l, acc_r;
                integer g1, g2, g3;
                logic [15:0] prev_l, prev_r;
                frame_t dac_cur;
                h1 = 0;                 // left history
                h2 = 0;
                h3 = 0;
                g1 = 0;                 // right history
                g2 = 0;
                g3 = 0;
                sel_idx = 0;
                dac_cur = '0;
                wait (codec_run);
                forever begin
                        for (i = 0; i < 5; i++) begin
                                smp_l[i] = $random(seed);
                                smp_r[i] = $random(seed);
                        end
                        for (s = 0; s < 32; s++) begin
                                @(negedge bclk);
                                if (s == 0) begin
                                        lrclk = 1'b0;
                                        if (cur_frame >= 0) begin
                                                // previous frame is now complete
                                                x = $signed(prev_l);
                                                acc_l = (x + 3*h1 + 3*h2 + h3) >>> 3;
                                                h3 = h2;
                                                h2 = h1;
                                                h1 = x;
                                                x = $signed(prev_r);
                                                acc_r = (x + 3*g1 + 3*g2 + g3) >>> 3;
                                                g3 = g2;
                                                g2 = g1;
                                                g1 = x;
                                                exp_raw_q.push_back({prev_l, prev_r});
                                                exp_fir_q.push_back({acc_l[15:0], acc_r[15:0]});
                                                dac_frames[cur_frame] = dac_cur;
                                        end
                                        cur_frame++;
                                        dac_cur = '0;
                                        -> frame_start;
                                end
                                if (s == 16)
                                        lrclk = 1'b1;
                                // msb goes out together with the lrclk change
                                adcdat = (s < 16) ? smp_l[0][15-s] : smp_r[0][31-s];
                                din1   = (s < 16) ? smp_l[1][15-s] : smp_r[1][31-s];
                                din2   = (s < 16) ? smp_l[2][15-s] : smp_r[2][31-s];
                                din3   = (s < 16) ? smp_l[3][15-s] : smp_r[3][31-s];
                                din4   = (s < 16) ? smp_l[4][15-s] : smp_r[4][31-s];
                                if (s == 8) begin
                                        sel_idx = (src_sel <= 3'd4) ? src_sel : 0;
                                        prev_l = smp_l[sel_idx];
                                        prev_r = smp_r[sel_idx];
                                end
                                @(posedge bclk);
                                // one bit delay, right lsb falls on the next frame start
                                if (s == 0 && cur_frame >= 1)
                                        dac_frames[cur_frame-1][0] = dacdat;
                                else if (s >= 1)
                                        dac_cur[32-s] = dacdat;
                        end
                end
        end

        // stream monitor, outputs sampled on clk falls
        always @(negedge clk) begin
                if (rst_n && stream_valid) begin
                        got_q.push_back(stream_data);
                        en_q.push_back(fir_en);
                        play_f_q.push_back(cur_frame + 1);     // frame that plays it
                end
        end

        // ====================
        // test tasks
        // ====================
        task automatic apply_config(input src_sel_t sel, input logic en);
                @(frame_start);
                @(negedge clk);
                src_sel = sel;
                fir_en  = en;
        endtask

        task automatic check_reset_state();
                while (cur_frame < 1) begin
                        @(negedge clk);
                        checks++;
                        assert (stream_valid === 1'b0 && dacdat === 1'b0 && stream_data === '0)
                        else begin
                                errors++;
                                $display("** Error at %0t ns: idle valid %b dacdat %b data %h",
                                         $time, stream_valid, dacdat, stream_data);
                        end
                        checks++;
                        // mic clocks follow the codec clocks
                        assert (mic_bclk === bclk && mic_lrclk === lrclk) else begin
                                errors++;
                                $display("** Error at %0t ns: mic clocks %b %b, expected %b %b",
                                         $time, mic_bclk, mic_lrclk, bclk, lrclk);
                        end
                end
        endtask

        task automatic check_stream(input integer n, input string tag);
                frame_t got, raw, filt, exp;
                logic en;
                integer i;
                for (i = 0; i < n; i++) begin
                        while (got_q.size() == 0)
                                @(negedge clk);
                        got = got_q.pop_front();
                        en  = en_q.pop_front();
                        if (exp_raw_q.size() == 0) begin
                                errors++;
                                $display("stream word appeared before any codec frame completed");
                        end else begin
                                raw  = exp_raw_q.pop_front();
                                filt = exp_fir_q.pop_front();
                                exp  = en ? filt : raw;
                                play_q.push_back(exp);
                                checks++;
                                assert (got === exp) else begin
                                        errors++;
                                        $display("** Error at %0t ns: %s word %h, expected %h",
                                                 $time, tag, got, exp);
                                end
                        end
                end
        endtask

        task automatic check_playback(input integer n);
                frame_t word, dac;
                integer f, i;
                for (i = 0; i < n; i++) begin
                        while (play_q.size() == 0 || play_f_q.size() == 0)
                                @(negedge clk);
                        word = play_q.pop_front();
                        f    = play_f_q.pop_front();
                        while (cur_frame < f + 2)       // frame f decoded, right lsb too
                                @(negedge clk);
                        dac = dac_frames[f];
                        checks++;
                        assert (dac === word) else begin
                                errors++;
                                $display("** Error at %0t ns: dacdat frame %0d %h, expected %h",
                                         $time, f, dac, word);
                        end
                end
        endtask

        // watchdog
        initial begin
                #(LIMIT_NS);
                $display("timeout, the tests did not finish in 40 frames");
                $display("ERRORS FOUND");
                $finish;
        end

        initial begin
                clk = 1'b0;
                rst_n = 1'b0;
                bclk = 1'b1;
                lrclk = 1'b1;
                adcdat = 1'b0;
                din1 = 1'b0;
                din2 = 1'b0;
                din3 = 1'b0;
                din4 = 1'b0;
                src_sel = 3'd0;
                fir_en = 1'b0;
                repeat (10) @(negedge clk);
                rst_n = 1'b1;
                repeat (4) @(negedge clk);
                codec_run = 1'b1;

                check_reset_state();
                check_stream(3, "bypass codec");
                apply_config(3'd0, 1'b1);
                check_stream(5, "fir codec");
                apply_config(3'd1, 1'b0);
                check_stream(2, "mic 1");
                apply_config(3'd2, 1'b0);
                check_stream(2, "mic 2");
                apply_config(3'd3, 1'b1);
                check_stream(2, "mic 3 fir");
                apply_config(3'd4, 1'b0);
                check_stream(2, "mic 4");
                apply_config(3'd6, 1'b0);
                check_stream(3, "select 6");
                check_playback(6);

                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/mic_pkg.sv
i2s/i2s_capture.sv
i2s/i2s_playback.sv
fir/fir_channel.sv
src/stream_ctrl.sv
src/mic_array_top.sv
tb/mic_array_props.sv
tb/tb_mic_array.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
        -f all.f \
        --top-module tb_mic_array \
        -Mdir obj_dir \
        && ./obj_dir/Vtb_mic_array | tee /dev/stderr | grep -q "NO ERRORS" \
        && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }
